//--- rtl/lumi_rx_pkg.sv
// Link receiver shared definitions
package lumi_rx_pkg;

   //##################################################
   // Widths
   //##################################################
   localparam int CW     = 32;                // Command and phy word
   localparam int AW     = 32;                // Address
   localparam int DW     = 64;                // Data, two words at most
   localparam int CRDT_W = 16;                // Credit counters
   localparam int PKT_W  = CW + AW + AW + DW; // Assembled packet

   //##################################################
   // Header word fields
   //##################################################
   localparam int KIND_LSB     = 0;  // Kind, two bits
   localparam int HAS_DATA_BIT = 2;  // Packet carries data
   localparam int LEN_BIT      = 3;  // 0 = one data word, 1 = two
   localparam int LINK_SUB_LSB = 4;  // Link sub-code, four bits
   localparam int LINK_VAL_LSB = 16; // Credit value of a link command

   // Packet kind, zero is reserved on the wire
   typedef enum logic [1:0] {
      KIND_NONE = 2'd0,
      KIND_REQ  = 2'd1,
      KIND_RESP = 2'd2,
      KIND_LINK = 2'd3
   } kind_e;

   // Link sub-codes carrying remote credits
   localparam logic [3:0] SUB_CRDT_REQ  = 4'd1;
   localparam logic [3:0] SUB_CRDT_RESP = 4'd2;

   //##################################################
   // FIFO entry
   //##################################################
   // Beat lengths per packet
   //   link            1 (cmd)
   //   no data         3 (cmd, dstaddr, srcaddr)
   //   data, len=0     4
   //   data, len=1     5
   typedef struct packed {
      logic          last; // Final beat of packet
      logic [CW-1:0] data;
   } beat_t;

endpackage

//--- rtl/rx_framer.sv
// Phy input framer
`timescale 1ns/1ps

module rx_framer
   import lumi_rx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic [CW-1:0] phy_rxdata,
   input  logic          phy_rxvld,
   output beat_t         beat,
   output logic          req_wr,
   output logic          resp_wr,
   output logic          link_wr
);

   typedef enum logic {
      HEAD,
      BODY
   } state_e;

   state_e        state;
   logic [CW-1:0] rxdata;     // Sampled phy word
   logic          rxvalid;    // Sampled phy valid
   kind_e         hdr_kind;   // Kind decoded from current word
   kind_e         kind_q;     // Kind held for body beats
   kind_e         cur_kind;
   logic [2:0]    hdr_beats;  // Packet length in beats
   logic [2:0]    remain;     // Beats still to come after this one
   logic          last;

   //##################################################
   // Input sampling
   //##################################################
   always_ff @(posedge clk)
   begin
      rxdata <= phy_rxdata; // No reset on payload
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rxvalid <= 1'b0;
      else
         rxvalid <= phy_rxvld;
   end

   //##################################################
   // Header decode
   //##################################################
   assign hdr_kind = kind_e'(rxdata[KIND_LSB +: 2]);

   // Length rule
   always_comb
   begin
      if (hdr_kind == KIND_LINK)
         hdr_beats = 3'd1;          // Command only
      else if (!rxdata[HAS_DATA_BIT])
         hdr_beats = 3'd3;          // Cmd and two addresses
      else if (rxdata[LEN_BIT])
         hdr_beats = 3'd5;
      else
         hdr_beats = 3'd4;
   end

   // Header beat uses live decode, body beats the stored kind
   assign cur_kind = (state == HEAD) ? hdr_kind : kind_q;
   assign last     = (state == HEAD) ? (hdr_beats == 3'd1) : (remain == 3'd1);

   //##################################################
   // Framing FSM
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state  <= HEAD;
         remain <= 3'd0;
         kind_q <= KIND_NONE;
      end
      else if (rxvalid)
      begin
         case (state)
            HEAD:
               if (hdr_beats != 3'd1)
               begin
                  state  <= BODY;
                  remain <= hdr_beats - 3'd1;
                  kind_q <= hdr_kind;
               end
            BODY:
            begin
               remain <= remain - 3'd1;
               if (remain == 3'd1)
                  state <= HEAD; // Last body beat
            end
            default: state <= HEAD;
         endcase
      end
   end

   // FIFO steering, written one edge after sampling
   assign beat.data = rxdata;
   assign beat.last = last;
   assign req_wr    = rxvalid && (cur_kind == KIND_REQ);
   assign resp_wr   = rxvalid && (cur_kind == KIND_RESP);
   assign link_wr   = rxvalid && (cur_kind == KIND_LINK);

   // Sender never emits the reserved kind
   a_no_rsvd_kind: assert property (@(posedge clk) disable iff (!nreset)
      (rxvalid && state == HEAD) |-> (hdr_kind != KIND_NONE))
      else $error("framer: header with reserved kind");

endmodule

//--- rtl/rx_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ps

module rx_fifo
   import lumi_rx_pkg::*;
#(
   parameter int  DEPTH  = 8,
   parameter type item_t = logic [CW-1:0]
)
(
   input  logic  clk,
   input  logic  nreset,
   input  logic  wr,
   input  item_t din,
   input  logic  rd,
   output item_t dout,
   output logic  empty,
   output logic  full
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1; // Pointer width
   localparam int NW = $clog2(DEPTH + 1);               // Count width

   item_t         mem [DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [NW-1:0] count;  // Occupancy

   // Storage, head item shown at dout
   always_ff @(posedge clk)
   begin
      if (wr)
         mem[wr_ptr] <= din;
   end

   assign dout  = mem[rd_ptr];
   assign empty = (count == '0);
   assign full  = (count == NW'(DEPTH));

   // Pointers wrap at DEPTH
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr)
            wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // Both or neither
         endcase
      end
   end

   // Overflow means credit loss upstream
   a_no_overflow: assert property (@(posedge clk) disable iff (!nreset) wr |-> !full)
      else $error("fifo: write while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (!nreset) rd |-> !empty)
      else $error("fifo: read while empty");

endmodule

//--- rtl/rx_assembler.sv
// Packet assembler and output ports
`timescale 1ns/1ps

module rx_assembler
   import lumi_rx_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  beat_t         req_item,
   input  beat_t         resp_item,
   input  logic          req_empty,
   input  logic          resp_empty,
   input  logic [CW-1:0] link_item,
   input  logic          link_empty,
   input  logic          req_ready,
   input  logic          resp_ready,
   output logic          req_rd,
   output logic          resp_rd,
   output logic          link_rd,
   output logic          req_valid,
   output logic [CW-1:0] req_cmd,
   output logic [AW-1:0] req_dstaddr,
   output logic [AW-1:0] req_srcaddr,
   output logic [DW-1:0] req_data,
   output logic          resp_valid,
   output logic [CW-1:0] resp_cmd,
   output logic [AW-1:0] resp_dstaddr,
   output logic [AW-1:0] resp_srcaddr,
   output logic [DW-1:0] resp_data,
   output logic [CW-1:0] link_cmd,
   output logic          link_cmd_valid
);

   kind_e            fresh;   // Choice at a packet boundary
   kind_e            sel;     // Source in use this cycle
   kind_e            sel_q;   // Source held across a packet
   logic [2:0]       widx;    // Word index into packet register
   logic [PKT_W-1:0] pkt;
   beat_t            cur_item;
   logic             stall;
   logic             pkt_rd;

   //##################################################
   // Arbitration
   //##################################################
   // Priority link, then response, then request
   always_comb
   begin
      if (!link_empty)
         fresh = KIND_LINK;
      else if (!resp_empty)
         fresh = KIND_RESP;
      else if (!req_empty)
         fresh = KIND_REQ;
      else
         fresh = KIND_NONE;
   end

   assign sel = (widx == 3'd0) ? fresh : sel_q; // Held until last beat

   // Held packet blocks every FIFO
   assign stall = (req_valid && !req_ready) || (resp_valid && !resp_ready);

   assign link_rd = !stall && (sel == KIND_LINK) && !link_empty;
   assign resp_rd = !stall && (sel == KIND_RESP) && !resp_empty;
   assign req_rd  = !stall && (sel == KIND_REQ) && !req_empty;

   assign pkt_rd   = req_rd || resp_rd;
   assign cur_item = (sel == KIND_RESP) ? resp_item : req_item;

   // Link words go straight to credit capture
   assign link_cmd       = link_item;
   assign link_cmd_valid = link_rd;

   //##################################################
   // Packet register
   //##################################################
   always_ff @(posedge clk)
   begin
      if (pkt_rd)
      begin
         if (widx == 3'd0)
            pkt <= {{(PKT_W - CW){1'b0}}, cur_item.data}; // Clears stale data
         else
            pkt[widx * CW +: CW] <= cur_item.data;
      end
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         widx       <= 3'd0;
         sel_q      <= KIND_NONE;
         req_valid  <= 1'b0;
         resp_valid <= 1'b0;
      end
      else
      begin
         // Accepted packets leave
         if (req_valid && req_ready)
            req_valid <= 1'b0;
         if (resp_valid && resp_ready)
            resp_valid <= 1'b0;
         if (pkt_rd)
         begin
            if (widx == 3'd0)
               sel_q <= sel;
            if (cur_item.last)
            begin
               widx <= 3'd0;
               if (sel == KIND_REQ)
                  req_valid <= 1'b1;
               else
                  resp_valid <= 1'b1;
            end
            else
               widx <= widx + 3'd1;
         end
      end
   end

   // Both ports read the one packet register, valid tells them apart
   assign req_cmd      = pkt[0 +: CW];
   assign req_dstaddr  = pkt[CW +: AW];
   assign req_srcaddr  = pkt[CW + AW +: AW];
   assign req_data     = pkt[CW + 2 * AW +: DW];
   assign resp_cmd     = pkt[0 +: CW];
   assign resp_dstaddr = pkt[CW +: AW];
   assign resp_srcaddr = pkt[CW + AW +: AW];
   assign resp_data    = pkt[CW + 2 * AW +: DW];

   // Held output stays put until taken
   a_req_hold: assert property (@(posedge clk) disable iff (!nreset)
      (req_valid && !req_ready) |=>
         (req_valid && $stable({req_cmd, req_dstaddr, req_srcaddr, req_data})))
      else $error("assembler: request port changed while held");

   a_resp_hold: assert property (@(posedge clk) disable iff (!nreset)
      (resp_valid && !resp_ready) |=>
         (resp_valid && $stable({resp_cmd, resp_dstaddr, resp_srcaddr, resp_data})))
      else $error("assembler: response port changed while held");

endmodule

//--- rtl/rx_credit.sv
// Local and remote credit tracking
`timescale 1ns/1ps

module rx_credit
   import lumi_rx_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              csr_en,
   input  logic [CRDT_W-1:0] csr_crdt_req_init,
   input  logic [CRDT_W-1:0] csr_crdt_resp_init,
   input  logic              req_rd,
   input  logic              resp_rd,
   input  logic [CW-1:0]     link_cmd,
   input  logic              link_cmd_valid,
   output logic [CRDT_W-1:0] loc_crdt_req,
   output logic [CRDT_W-1:0] loc_crdt_resp,
   output logic [CRDT_W-1:0] rmt_crdt_req,
   output logic [CRDT_W-1:0] rmt_crdt_resp
);

   logic [3:0]        link_sub;
   logic [CRDT_W-1:0] link_val;

   //##################################################
   // Local credits, returned to sender
   //##################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         loc_crdt_req  <= '0;
         loc_crdt_resp <= '0;
      end
      else if (!csr_en)
      begin
         loc_crdt_req  <= csr_crdt_req_init;  // Preload while disabled
         loc_crdt_resp <= csr_crdt_resp_init;
      end
      else
      begin
         if (req_rd)
            loc_crdt_req <= loc_crdt_req + 1'b1;   // Wraps mod 2^16
         if (resp_rd)
            loc_crdt_resp <= loc_crdt_resp + 1'b1;
      end
   end

   // Remote credits from link commands
   assign link_sub = link_cmd[LINK_SUB_LSB +: 4];
   assign link_val = link_cmd[LINK_VAL_LSB +: CRDT_W];

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         rmt_crdt_req  <= '0;
         rmt_crdt_resp <= '0;
      end
      else if (link_cmd_valid)
      begin
         if (link_sub == SUB_CRDT_REQ)
            rmt_crdt_req <= link_val;
         if (link_sub == SUB_CRDT_RESP)
            rmt_crdt_resp <= link_val;
         // Other sub-codes ignored
      end
   end

endmodule

//--- rtl/lumi_rx.sv
// Link receiver top level
`timescale 1ns/1ps

module lumi_rx
   import lumi_rx_pkg::*;
#(
   parameter int FIFO_DEPTH = 8 // Beats per credit FIFO
)
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              csr_en,
   input  logic [CRDT_W-1:0] csr_crdt_req_init,
   input  logic [CRDT_W-1:0] csr_crdt_resp_init,
   input  logic [CW-1:0]     phy_rxdata,
   input  logic              phy_rxvld,
   // Request port
   output logic              req_valid,
   output logic [CW-1:0]     req_cmd,
   output logic [AW-1:0]     req_dstaddr,
   output logic [AW-1:0]     req_srcaddr,
   output logic [DW-1:0]     req_data,
   input  logic              req_ready,
   // Response port
   output logic              resp_valid,
   output logic [CW-1:0]     resp_cmd,
   output logic [AW-1:0]     resp_dstaddr,
   output logic [AW-1:0]     resp_srcaddr,
   output logic [DW-1:0]     resp_data,
   input  logic              resp_ready,
   // Credits
   output logic [CRDT_W-1:0] loc_crdt_req,
   output logic [CRDT_W-1:0] loc_crdt_resp,
   output logic [CRDT_W-1:0] rmt_crdt_req,
   output logic [CRDT_W-1:0] rmt_crdt_resp
);

   beat_t         beat;
   logic          req_wr;
   logic          resp_wr;
   logic          link_wr;
   beat_t         req_item;
   beat_t         resp_item;
   logic [CW-1:0] link_item;
   logic          req_empty;
   logic          resp_empty;
   logic          link_empty;
   logic          req_rd;
   logic          resp_rd;
   logic          link_rd;
   logic [CW-1:0] link_cmd;
   logic          link_cmd_valid;

   rx_framer framer (.clk, .nreset, .phy_rxdata, .phy_rxvld,
                     .beat, .req_wr, .resp_wr, .link_wr);

   // Credit controlled FIFOs
   rx_fifo #(.DEPTH(FIFO_DEPTH), .item_t(beat_t)) req_fifo (
      .clk, .nreset, .wr(req_wr), .din(beat), .rd(req_rd),
      .dout(req_item), .empty(req_empty), .full());

   rx_fifo #(.DEPTH(FIFO_DEPTH), .item_t(beat_t)) resp_fifo (
      .clk, .nreset, .wr(resp_wr), .din(beat), .rd(resp_rd),
      .dout(resp_item), .empty(resp_empty), .full());

   // Link commands, rate limited by sender
   rx_fifo #(.DEPTH(2), .item_t(logic [CW-1:0])) link_fifo (
      .clk, .nreset, .wr(link_wr), .din(beat.data), .rd(link_rd),
      .dout(link_item), .empty(link_empty), .full());

   rx_assembler assembler (
      .clk, .nreset, .req_item, .resp_item, .req_empty, .resp_empty,
      .link_item, .link_empty, .req_ready, .resp_ready,
      .req_rd, .resp_rd, .link_rd,
      .req_valid, .req_cmd, .req_dstaddr, .req_srcaddr, .req_data,
      .resp_valid, .resp_cmd, .resp_dstaddr, .resp_srcaddr, .resp_data,
      .link_cmd, .link_cmd_valid);

   rx_credit credit (
      .clk, .nreset, .csr_en, .csr_crdt_req_init, .csr_crdt_resp_init,
      .req_rd, .resp_rd, .link_cmd, .link_cmd_valid,
      .loc_crdt_req, .loc_crdt_resp, .rmt_crdt_req, .rmt_crdt_resp);

endmodule

//--- test/lumi_rx_model.svh
// Receiver reference model
`ifndef LUMI_RX_MODEL_SVH
`define LUMI_RX_MODEL_SVH

   // Fields of one delivered packet, as seen on a port
   typedef struct packed {
      logic [CW-1:0] cmd;
      logic [AW-1:0] dstaddr;
      logic [AW-1:0] srcaddr;
      logic [DW-1:0] data;
   } pkt_t;

   logic [31:0] rng_state = 32'h25ae7697;
   pkt_t        req_q[$];   // Expected requests, sending order
   pkt_t        resp_q[$];  // Expected responses
   logic [31:0] beat_q[$];  // Words of the packet being sent

   function automatic logic [31:0] xorshift32();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // One request or response by the length rule
   function automatic void build_packet(input logic is_resp, input logic has_data,
                                        input logic len);
      pkt_t p;
      p = '0;                                     // Unused data stays zero
      p.cmd = xorshift32();
      p.cmd[KIND_LSB +: 2] = is_resp ? KIND_RESP : KIND_REQ;
      p.cmd[HAS_DATA_BIT]  = has_data;
      p.cmd[LEN_BIT]       = len;
      p.dstaddr = xorshift32();
      p.srcaddr = xorshift32();
      beat_q = {p.cmd, p.dstaddr, p.srcaddr};
      if (has_data)
      begin
         p.data[31:0] = xorshift32();             // First data word low
         beat_q.push_back(p.data[31:0]);
         if (len)
         begin
            p.data[63:32] = xorshift32();
            beat_q.push_back(p.data[63:32]);
         end
      end
      if (is_resp)
         resp_q.push_back(p);
      else
         req_q.push_back(p);
   endfunction

   // Link command word with sub-code and credit value
   function automatic logic [CW-1:0] link_word(input logic [3:0] sub, input logic [15:0] val);
      logic [CW-1:0] w;
      w = '0;
      w[KIND_LSB +: 2]       = KIND_LINK;
      w[LINK_SUB_LSB +: 4]   = sub;
      w[LINK_VAL_LSB +: 16]  = val;
      return w;
   endfunction

`endif

//--- test/tb_lumi_rx.sv
// Link receiver testbench
`timescale 1ns/1ps

module tb_lumi_rx
   import lumi_rx_pkg::*;
();

   localparam int          FIFO_DEPTH  = 8;
   localparam int          N_RAND      = 150;       // Random packets
   localparam logic [15:0] REQ_INIT    = 16'hfffa;  // Wraps during traffic
   localparam logic [15:0] RESP_INIT   = 16'h0040;
   localparam int          STIM_CYCLES = 10 + 6 * 8 + N_RAND * 8 + 4 * 20;

   logic              clk;
   logic              nreset;
   logic              csr_en;
   logic [CRDT_W-1:0] csr_crdt_req_init;
   logic [CRDT_W-1:0] csr_crdt_resp_init;
   logic [CW-1:0]     phy_rxdata;
   logic              phy_rxvld;
   logic              req_valid;
   logic [CW-1:0]     req_cmd;
   logic [AW-1:0]     req_dstaddr;
   logic [AW-1:0]     req_srcaddr;
   logic [DW-1:0]     req_data;
   logic              req_ready;
   logic              resp_valid;
   logic [CW-1:0]     resp_cmd;
   logic [AW-1:0]     resp_dstaddr;
   logic [AW-1:0]     resp_srcaddr;
   logic [DW-1:0]     resp_data;
   logic              resp_ready;
   logic [CRDT_W-1:0] loc_crdt_req;
   logic [CRDT_W-1:0] loc_crdt_resp;
   logic [CRDT_W-1:0] rmt_crdt_req;
   logic [CRDT_W-1:0] rmt_crdt_resp;

   int          n_checks    = 0;
   int          n_errors    = 0;
   int          test_errors = 0;           // Error count at test start
   int          n_req_beats = 0;
   int          n_resp_beats = 0;
   logic [15:0] sent_req  = REQ_INIT - 16'(FIFO_DEPTH);  // Sender beat counts
   logic [15:0] sent_resp = RESP_INIT - 16'(FIFO_DEPTH);
   logic        bp_on = 1'b0;              // Random ready back-pressure

   `include "lumi_rx_model.svh"

   lumi_rx #(.FIFO_DEPTH(FIFO_DEPTH)) uut (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;                  // 100 ns period

   //##################################################
   // Checking helpers
   //##################################################
   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] got);
      n_checks++;
      assert (got === exp)
      else
      begin
         $display("** Error: %s expected %h got %h", name, exp, got);
         n_errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      n_checks++;
      assert (cond)
      else
      begin
         $display("Failure: %s", what);
         n_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      $display("%-20s %s, %0d errors", name,
               (n_errors == test_errors) ? "ok" : "FAILED", n_errors - test_errors);
      test_errors = n_errors;
   endtask

   // Delivered packet against the head of its port queue
   task automatic compare_packet(input logic is_resp, input pkt_t got);
      pkt_t  exp;
      string port;
      port = is_resp ? "resp" : "req";
      if ((is_resp && resp_q.size() == 0) || (!is_resp && req_q.size() == 0))
      begin
         check_true(1'b0, {"packet on ", port, " port with none expected"});
         return;
      end
      if (is_resp)
         exp = resp_q.pop_front();
      else
         exp = req_q.pop_front();
      check_value({port, "_cmd"}, 64'(exp.cmd), 64'(got.cmd));
      check_value({port, "_dstaddr"}, 64'(exp.dstaddr), 64'(got.dstaddr));
      check_value({port, "_srcaddr"}, 64'(exp.srcaddr), 64'(got.srcaddr));
      check_value({port, "_data"}, exp.data, got.data);
   endtask

   // Valid and ready are both settled mid-cycle
   always @(negedge clk)
   begin
      if (nreset && req_valid && req_ready)
         compare_packet(1'b0, {req_cmd, req_dstaddr, req_srcaddr, req_data});
      if (nreset && resp_valid && resp_ready)
         compare_packet(1'b1, {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data});
   end

   //##################################################
   // Stimulus helpers
   //##################################################
   // Next edge, then drive 1 ns later
   task automatic tick();
      logic [31:0] r;
      @(posedge clk);
      #1;
      r = xorshift32();
      req_ready  = bp_on ? (r[1:0] != 2'd0) : 1'b1;  // Ready 3 of 4 cycles
      resp_ready = bp_on ? (r[3:2] != 2'd0) : 1'b1;
   endtask

   function automatic logic has_credit(input logic is_resp);
      logic [15:0] avail;
      avail = is_resp ? (loc_crdt_resp - sent_resp) : (loc_crdt_req - sent_req);
      return avail != 16'd0;
   endfunction

   task automatic send_word(input logic [1:0] kind, input logic [CW-1:0] data);
      while ((kind == KIND_REQ && !has_credit(1'b0)) ||
             (kind == KIND_RESP && !has_credit(1'b1)))
         tick();                           // Hold until a credit returns
      phy_rxdata = data;
      phy_rxvld  = 1'b1;
      if (kind == KIND_REQ)
      begin
         sent_req = sent_req + 16'd1;
         n_req_beats++;
      end
      else if (kind == KIND_RESP)
      begin
         sent_resp = sent_resp + 16'd1;
         n_resp_beats++;
      end
      tick();
      phy_rxvld = 1'b0;
   endtask

   task automatic send_packet(input logic is_resp, input logic has_data, input logic len);
      build_packet(is_resp, has_data, len);
      while (beat_q.size() != 0)
         send_word(is_resp ? KIND_RESP : KIND_REQ, beat_q.pop_front());
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while ((req_q.size() != 0 || resp_q.size() != 0) && n < 2000)
      begin
         tick();
         n++;
      end
      check_true(req_q.size() == 0 && resp_q.size() == 0,
                 "expected packets still missing after 2000 cycles");
   endtask

   //##################################################
   // Test sequence
   //##################################################
   initial
   begin
      logic [31:0] r;
      logic [15:0] val;
      logic [3:0]  sub;
      logic [15:0] old_req;
      logic [15:0] old_resp;
      logic [15:0] exp_req;
      logic [15:0] exp_resp;
      nreset             = 1'b0;
      csr_en             = 1'b0;
      csr_crdt_req_init  = REQ_INIT;
      csr_crdt_resp_init = RESP_INIT;
      phy_rxdata         = '0;
      phy_rxvld          = 1'b0;
      req_ready          = 1'b1;
      resp_ready         = 1'b1;
      repeat (4) @(posedge clk);           // Reset held 4 cycles
      #1;
      nreset = 1'b1;
      tick();
      tick();

      // Reset and init
      check_value("req_valid", 64'd0, 64'(req_valid));
      check_value("resp_valid", 64'd0, 64'(resp_valid));
      check_value("rmt_crdt_req", 64'd0, 64'(rmt_crdt_req));
      check_value("rmt_crdt_resp", 64'd0, 64'(rmt_crdt_resp));
      check_value("loc_crdt_req", 64'(REQ_INIT), 64'(loc_crdt_req));
      check_value("loc_crdt_resp", 64'(RESP_INIT), 64'(loc_crdt_resp));
      csr_en = 1'b1;
      tick();
      finish_test("reset and init");

      // Each form once per port
      for (int k = 0; k < 6; k++)
      begin
         send_packet(k >= 3, (k % 3) != 0, (k % 3) == 2);
         wait_drained();
      end
      finish_test("single packets");

      // Mixed traffic under back-pressure
      bp_on = 1'b1;
      for (int k = 0; k < N_RAND; k++)
      begin
         r = xorshift32();
         send_packet(r[0], r[1], r[2]);
         if (r[6:5] == 2'd0)
            tick();                        // Idle gap
      end
      wait_drained();
      bp_on = 1'b0;
      tick();
      check_value("req_valid", 64'd0, 64'(req_valid));
      check_value("resp_valid", 64'd0, 64'(resp_valid));
      finish_test("random traffic");

      // Pops return one credit per beat
      exp_req  = REQ_INIT + 16'(n_req_beats);   // Wraps mod 2^16
      exp_resp = RESP_INIT + 16'(n_resp_beats);
      check_value("loc_crdt_req", 64'(exp_req), 64'(loc_crdt_req));
      check_value("loc_crdt_resp", 64'(exp_resp), 64'(loc_crdt_resp));
      finish_test("credit counts");

      // Remote credit capture, one link beat per 16 cycles
      for (int k = 0; k < 4; k++)
      begin
         r = xorshift32();
         val = r[31:16];
         case (k)
            0:       sub = SUB_CRDT_REQ;
            1:       sub = SUB_CRDT_RESP;
            2:       sub = 4'd5;           // Not a credit update
            default: sub = 4'd0;
         endcase
         old_req  = rmt_crdt_req;
         old_resp = rmt_crdt_resp;
         send_word(KIND_LINK, link_word(sub, val));
         for (int c = 0; c < 16; c++)
         begin
            tick();
            check_true(!req_valid && !resp_valid, "link command raised an output valid");
         end
         check_value("rmt_crdt_req", 64'((sub == SUB_CRDT_REQ) ? val : old_req),
                     64'(rmt_crdt_req));
         check_value("rmt_crdt_resp", 64'((sub == SUB_CRDT_RESP) ? val : old_resp),
                     64'(rmt_crdt_resp));
      end
      finish_test("link commands");

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   // Watchdog, four times the expected stimulus length
   initial
   begin
      #(4 * STIM_CYCLES * 100);
      $display("Timeout: run did not finish within %0d cycles", 4 * STIM_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+test
rtl/lumi_rx_pkg.sv
rtl/rx_framer.sv
rtl/rx_fifo.sv
rtl/rx_assembler.sv
rtl/rx_credit.sv
rtl/lumi_rx.sv
test/tb_lumi_rx.sv

//--- run.sh
#!/bin/sh
# Compile and run the link receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_lumi_rx -f verilog.f

./obj_dir/Vtb_lumi_rx | tee log.txt

if grep -q "^All checks passed$" log.txt
then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
